// File: include/posit_consts.svh
// Posit format constants and APB register map for the 32-bit posit multiplier
// Included by the package, the RTL and the testbench
`ifndef POSIT_CONSTS_SVH
`define POSIT_CONSTS_SVH

// Posit format
`define POSIT_NBITS 32
`define POSIT_ES 2
`define POSIT_FBITS 27              // Fraction bits kept, hidden one excluded

// Serialized value is sign, 8-bit scale, fraction, inf, zero
`define POSIT_SER_WIDTH 38

// APB byte offsets
`define REG_OPA 4'h0
`define REG_OPB 4'h4                // Write starts a product
`define REG_RESULT 4'h8
`define REG_STATUS 4'hC             // Bit 0 done, bit 1 inf, bit 2 zero

`endif

// File: hw/posit_defines.sv
// Shared types for the posit datapath
// The decoded value and the multiplier product that feeds the normalizer
`include "posit_consts.svh"

package posit_defines;

    // Decoded posit, 38 bits, MSB first
    typedef struct packed {
        logic                    sgn;       // Sign of the value
        logic signed [7:0]       scale;     // Regime * 2^es + exponent
        logic [`POSIT_FBITS-1:0] fraction;  // Hidden one not stored
        logic                    inf;       // NaR
        logic                    zero;
    } value;

    // Multiplier output
    typedef struct packed {
        value ser;                          // Serialized product for the normalizer
        logic truncated;                    // OR of product bits below the fraction
    } product_t;

endpackage

// File: hw/posit_apb_slave.sv
// APB register file for the posit multiplier
// OPA and OPB are written by the host, RESULT and STATUS are read back
`timescale 1ns/1ps
`include "posit_consts.svh"

module posit_apb_slave (
    input  logic                    clk,
    input  logic                    rst,
    // APB
    input  logic [3:0]              paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    // Result from the normalizer
    input  logic                    res_valid,
    input  logic [`POSIT_NBITS-1:0] res_posit,
    input  logic                    res_inf,
    input  logic                    res_zero,
    // Operands to the pipeline
    output logic [`POSIT_NBITS-1:0] opa,
    output logic [`POSIT_NBITS-1:0] opb,
    output logic                    start
);

    logic                    wr_en;       // Completed write transfer
    logic [`POSIT_NBITS-1:0] result_q;
    logic                    done_q;
    logic                    inf_q;
    logic                    zero_q;

    // No wait states, no errors
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    assign wr_en = psel & penable & pwrite & pready;

    // Operand registers and start strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            opa   <= '0;
            opb   <= '0;
            start <= 1'b0;
        end else begin
            start <= wr_en && (paddr == `REG_OPB);  // One cycle pulse
            if (wr_en && (paddr == `REG_OPA)) begin
                opa <= pwdata;
            end
            if (wr_en && (paddr == `REG_OPB)) begin
                opb <= pwdata;
            end
        end
    end

    // Result and status, latest finished product wins
    always_ff @(posedge clk) begin
        if (rst) begin
            result_q <= '0;
            done_q   <= 1'b0;
            inf_q    <= 1'b0;
            zero_q   <= 1'b0;
        end else if (res_valid) begin
            result_q <= res_posit;
            done_q   <= 1'b1;
            inf_q    <= res_inf;
            zero_q   <= res_zero;
        end else if (wr_en && (paddr == `REG_OPB)) begin
            done_q <= 1'b0;                         // New product pending
        end
    end

    // Read mux, zero wait states
    always_comb begin
        case (paddr)
            `REG_OPA:    prdata = opa;
            `REG_OPB:    prdata = opb;
            `REG_RESULT: prdata = result_q;
            `REG_STATUS: prdata = {29'b0, zero_q, inf_q, done_q};
            default:     prdata = '0;               // Unmapped
        endcase
    end

endmodule

// File: hw/posit_extract.sv
// Posit decoder, combinational
// Splits one posit into sign, scale, fraction and the NaR and zero flags
`timescale 1ns/1ps
`include "posit_consts.svh"

module posit_extract import posit_defines::*; (
    input  logic [`POSIT_NBITS-1:0] in,
    output value                    out
);

    localparam int BW = `POSIT_NBITS - 1;   // Body width, sign excluded

    logic                    is_zero;
    logic                    is_nar;
    logic                    special;
    logic [`POSIT_NBITS-1:0] mag;           // Absolute value
    logic [BW-1:0]           body;
    logic                    r0;            // First regime bit
    logic [BW-1:0]           run_bits;
    logic [5:0]              run_len;       // Regime run length, 1..31
    logic signed [7:0]       k;             // Regime value
    logic [BW-1:0]           rest;          // Exponent and fraction, left aligned
    logic [`POSIT_ES-1:0]    exp_bits;

    assign is_zero = (in == '0);
    assign is_nar  = (in == {1'b1, {BW{1'b0}}});
    assign special = is_zero | is_nar;

    // Negative posits decode from the two's complement
    assign mag  = in[`POSIT_NBITS-1] ? -in : in;
    assign body = mag[BW-1:0];
    assign r0   = body[BW-1];

    // Regime run turned into leading zeros
    assign run_bits = r0 ? ~body : body;

    // Leading zero count, the highest set bit wins
    always_comb begin
        run_len = 6'(BW);                    // Run fills the whole body
        for (int i = 0; i < BW; i++) begin
            if (run_bits[i]) begin
                run_len = 6'(BW - 1 - i);
            end
        end
    end

    // Run of ones gives k = m - 1, run of zeros gives k = -m
    assign k = r0 ? ($signed({2'b00, run_len}) - 8'sd1) : -$signed({2'b00, run_len});

    // Drop regime and terminator
    assign rest     = body << (run_len + 6'd1);
    assign exp_bits = rest[BW-1 -: `POSIT_ES];

    always_comb begin
        out      = '0;
        out.inf  = is_nar;
        out.zero = is_zero;
        if (!special) begin
            out.sgn      = in[`POSIT_NBITS-1];
            out.scale    = (k <<< `POSIT_ES) + $signed({6'b0, exp_bits});
            out.fraction = rest[BW-`POSIT_ES-1 -: `POSIT_FBITS];
        end
    end

endmodule

// File: hw/posit_mult.sv
// Posit significand multiplier, combinational
// Multiplies two decoded values into a serialized product plus a truncation flag
`timescale 1ns/1ps
`include "posit_consts.svh"

module posit_mult import posit_defines::*; (
    input  value     a,
    input  value     b,
    output product_t prod
);

    localparam int SW = `POSIT_FBITS + 1;        // Significand with hidden one
    localparam int PW = 2 * SW;                  // Full product width
    localparam int ONE_LO = -(1 << `POSIT_ES);   // Scale window of a 2-bit regime
    localparam int ONE_HI = (1 << `POSIT_ES) - 1;

    logic [SW-1:0]           sig_a;
    logic [SW-1:0]           sig_b;
    logic [PW-1:0]           p;
    logic                    ovf;                // Product in [2, 4)
    logic [PW-1:0]           norm;
    logic [`POSIT_FBITS-1:0] frac_raw;
    logic [`POSIT_FBITS:0]   disc;               // Bits below the kept fraction
    logic signed [9:0]       scale_sum;
    logic                    near_one;
    logic                    round_up;
    logic [SW:0]             sig_r;              // Carry, hidden one, fraction
    logic signed [9:0]       scale_fin;
    logic signed [7:0]       scale_sat;
    logic                    is_inf;
    logic                    is_zero;

    assign sig_a = {1'b1, a.fraction};
    assign sig_b = {1'b1, b.fraction};
    assign p     = sig_a * sig_b;
    assign ovf   = p[PW-1];

    // Hidden one at PW-1 after this
    assign norm     = ovf ? p : (p << 1);
    assign frac_raw = norm[PW-2 -: `POSIT_FBITS];
    assign disc     = norm[PW-`POSIT_FBITS-2:0];

    assign scale_sum = a.scale + b.scale + $signed({9'b0, ovf});

    // With a 2-bit regime the posit keeps every fraction bit, so the guard
    // bit is lost past this point and rounding has to happen here
    assign near_one = (scale_sum >= ONE_LO) && (scale_sum <= ONE_HI);
    assign round_up = near_one & disc[`POSIT_FBITS] & (frac_raw[0] | (|disc[`POSIT_FBITS-1:0]));
    assign sig_r    = {2'b01, frac_raw} + {{SW{1'b0}}, round_up};

    // Carry out of rounding lands on 2.0 with an all-zero fraction
    assign scale_fin = scale_sum + $signed({9'b0, sig_r[SW]});

    // Clamp to the 8-bit field, normalizer clips further to maxpos or minpos
    always_comb begin
        if (scale_fin > 10'sd127) begin
            scale_sat = 8'sd127;
        end else if (scale_fin < -10'sd128) begin
            scale_sat = 8'sh80;                  // Most negative scale
        end else begin
            scale_sat = scale_fin[7:0];
        end
    end

    assign is_inf  = a.inf | b.inf;              // NaR beats zero
    assign is_zero = ~is_inf & (a.zero | b.zero);

    always_comb begin
        prod          = '0;
        prod.ser.inf  = is_inf;
        prod.ser.zero = is_zero;
        if (!(is_inf || is_zero)) begin
            prod.ser.sgn      = a.sgn ^ b.sgn;
            prod.ser.scale    = scale_sat;
            prod.ser.fraction = sig_r[`POSIT_FBITS-1:0];
            prod.truncated    = |disc;
        end
    end

endmodule

// File: hw/posit_normalize.sv
// Posit encoder with round to nearest even, combinational
// Turns a serialized value and its truncation flag back into a 32-bit posit
`timescale 1ns/1ps
`include "posit_consts.svh"

module posit_normalize import posit_defines::*; (
    input  logic [`POSIT_SER_WIDTH-1:0] in1,
    input  logic                        truncated,
    output logic [`POSIT_NBITS-1:0]     result,
    output logic                        inf,
    output logic                        zero
);

    localparam int BW = `POSIT_NBITS - 1;                     // Body width
    localparam int SW = 3 * `POSIT_NBITS;                     // Shift string width
    localparam int PAD = SW - `POSIT_NBITS - 1 - `POSIT_ES - `POSIT_FBITS;
    localparam int MAX_SCALE = (`POSIT_NBITS - 2) << `POSIT_ES;  // Scale of maxpos

    value                 in_v;
    logic signed [7:0]    scale_c;      // Clipped to the posit range
    logic signed [7:0]    k;            // Regime value
    logic                 neg;          // Negative regime
    logic [`POSIT_ES-1:0] exp_bits;
    logic [5:0]           shamt;        // Regime length, 1..31
    logic [SW-1:0]        str;          // Regime, exponent, fraction
    logic [SW-1:0]        shifted;
    logic [BW-1:0]        body;
    logic                 bafter;       // First bit past the kept bits
    logic                 sticky;
    logic                 round_up;
    logic [BW-1:0]        body_r;
    logic [BW-1:0]        body_s;

    assign in_v = value'(in1);

    // Outside the range snaps to maxpos or minpos, never to zero
    always_comb begin
        if (in_v.scale > MAX_SCALE) begin
            scale_c = 8'(MAX_SCALE);
        end else if (in_v.scale < -MAX_SCALE) begin
            scale_c = 8'(-MAX_SCALE);
        end else begin
            scale_c = in_v.scale;
        end
    end

    assign k        = scale_c >>> `POSIT_ES;     // Floor division
    assign exp_bits = scale_c[`POSIT_ES-1:0];
    assign neg      = scale_c[7];
    assign shamt    = neg ? 6'(-k) : 6'(k + 8'sd1);

    // Run of ~neg, terminator, exponent, fraction, room for shifted-out bits
    assign str = {{`POSIT_NBITS{~neg}}, neg, exp_bits, in_v.fraction, {PAD{1'b0}}};

    // Clip shifter, the window sits just under the run
    assign shifted = str >> shamt;
    assign body    = shifted[2*`POSIT_NBITS-1 -: BW];
    assign bafter  = shifted[`POSIT_NBITS];
    assign sticky  = truncated | (|shifted[`POSIT_NBITS-1:0]);

    // Ties go to an even last bit
    assign round_up = bafter & (body[0] | sticky);
    assign body_r   = body + {{(BW-1){1'b0}}, round_up};

    // Negative posits are two's complement of the body
    assign body_s = in_v.sgn ? -body_r : body_r;

    // NaR and zero override the encoding
    always_comb begin
        if (in_v.inf) begin
            result = {1'b1, {BW{1'b0}}};
        end else if (in_v.zero) begin
            result = '0;
        end else begin
            result = {in_v.sgn, body_s};
        end
    end

    assign inf  = in_v.inf;
    assign zero = ~in_v.inf & in_v.zero;

endmodule

// File: hw/posit_mul_apb.sv
// Top level of the APB posit multiplier
// Three pipeline stages from OPB write strobe to RESULT register
`timescale 1ns/1ps
`include "posit_consts.svh"

module posit_mul_apb import posit_defines::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic [`POSIT_NBITS-1:0] opa;
    logic [`POSIT_NBITS-1:0] opb;
    logic                    start;
    value                    ext_a;          // Decoded operands
    value                    ext_b;
    value                    s1_a;           // Stage 1
    value                    s1_b;
    logic                    s1_valid;
    product_t                mul_prod;
    product_t                s2_prod;        // Stage 2
    logic                    s2_valid;
    logic [`POSIT_NBITS-1:0] norm_result;
    logic                    norm_inf;
    logic                    norm_zero;

    posit_apb_slave u_apb_slave (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .res_valid (s2_valid),               // Stage 3 writes RESULT
        .res_posit (norm_result),
        .res_inf   (norm_inf),
        .res_zero  (norm_zero),
        .opa       (opa),
        .opb       (opb),
        .start     (start)
    );

    posit_extract u_extract_a (.in(opa), .out(ext_a));
    posit_extract u_extract_b (.in(opb), .out(ext_b));

    posit_mult u_mult (.a(s1_a), .b(s1_b), .prod(mul_prod));

    posit_normalize u_normalize (
        .in1       (s2_prod.ser),
        .truncated (s2_prod.truncated),
        .result    (norm_result),
        .inf       (norm_inf),
        .zero      (norm_zero)
    );

    // Stage valids, one product may enter every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= start;
            s2_valid <= s1_valid;
        end
    end

    // Stage payload
    always_ff @(posedge clk) begin
        s1_a    <= ext_a;
        s1_b    <= ext_b;
        s2_prod <= mul_prod;
    end

endmodule

// File: testbench/posit_mul_apb_chk.sv
// Concurrent checks on APB handshake and pipeline latency of the posit multiplier
// Bound into the top level, failures show up as assertion errors
`timescale 1ns/1ps
`include "posit_consts.svh"

module posit_mul_apb_chk (
    input logic       clk,
    input logic       rst,
    input logic [3:0] paddr,
    input logic       psel,
    input logic       penable,
    input logic       pwrite,
    input logic       pready,
    input logic       pslverr,
    input logic       start,
    input logic       done
);

    logic opb_wr;   // Completed OPB write

    assign opb_wr = psel && penable && pwrite && pready && (paddr == `REG_OPB);

    a_pready_high: assert property (@(posedge clk) disable iff (rst) pready)
        else $error("pready went low");
    a_no_slverr: assert property (@(posedge clk) disable iff (rst) !pslverr)
        else $error("pslverr was raised");
    a_start_cause: assert property (@(posedge clk) disable iff (rst) start |-> $past(opb_wr))
        else $error("start without an OPB write");
    a_start_pulse: assert property (@(posedge clk) disable iff (rst) opb_wr |=> start)
        else $error("OPB write gave no start pulse");
    a_done_latency: assert property (@(posedge clk) disable iff (rst) start |-> ##3 done)
        else $error("done missing three cycles after start");
    a_done_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> $past(start, 3))
        else $error("done rose without a start three cycles before");

endmodule

// Done flag lives inside the APB slave
bind posit_mul_apb posit_mul_apb_chk u_chk (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pready  (pready),
    .pslverr (pslverr),
    .start   (start),
    .done    (u_apb_slave.done_q)
);

// File: testbench/tb_posit_mul_apb.sv
// Directed testbench for the APB posit multiplier
// Drives APB on the falling edge and checks results against a bit-level posit model
`timescale 1ns/1ps
`include "posit_consts.svh"

module tb_posit_mul_apb;

    localparam int CLK_PERIOD = 100;
    localparam int N_TESTS = 6;
    localparam int OPS_PER_TEST = 1000;          // APB transfers, upper bound
    localparam int WATCHDOG_NS = N_TESTS * OPS_PER_TEST * 10 * CLK_PERIOD;
    localparam int DONE_LIMIT = 20;              // Cycles before done counts as lost
    localparam logic [31:0] NAR = 32'h8000_0000;

    logic        clk = 1'b0;
    logic        rst;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] lcg_state = 32'hd9247145;

    posit_mul_apb u_posit_mul_apb (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Hard stop if a handshake never completes
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, simulation did not finish in time");
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Fail at %0d ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        @(negedge clk);                          // Setup
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);                          // Access
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Back-to-back writes to one register, each setup right after the previous access
    task automatic apb_write_burst(input logic [3:0] addr, input logic [31:0] data [3]);
        foreach (data[i]) begin
            @(negedge clk);                      // Setup
            psel    = 1'b1;
            penable = 1'b0;
            pwrite  = 1'b1;
            paddr   = addr;
            pwdata  = data[i];
            @(negedge clk);                      // Access
            penable = 1'b1;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #1 data = prdata;                        // Mid access, stable
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Watches STATUS.done on the read mux, counts cycles since the OPB access
    task automatic wait_done(output int lat);
        lat   = 0;
        paddr = `REG_STATUS;
        #1;
        while (!prdata[0] && lat < DONE_LIMIT) begin
            @(negedge clk);
            #1;
            lat++;
        end
        checks++;
        assert (prdata[0]) else begin
            errors++;
            $display("done never rose within %0d cycles at %0d ns", DONE_LIMIT, $time);
        end
    endtask

    // Posit to sign, scale and significand with the hidden one
    function automatic void decode(input logic [31:0] p, output logic sgn, output int scale,
                                   output logic [27:0] sig);
        logic [31:0] m;
        logic [28:0] tail;                       // Exponent then fraction
        int i;
        int run;
        sgn = p[31];
        m   = p[31] ? -p : p;
        run = 0;
        i   = 30;
        while (i >= 0 && m[i] == m[30]) begin
            run++;
            i--;
        end
        i--;                                     // Skip terminator
        for (int j = 28; j >= 0; j--) begin
            tail[j] = (i >= 0) ? m[i] : 1'b0;
            i--;
        end
        scale = (m[30] ? run - 1 : -run) * 4 + int'(tail[28:27]);
        sig   = {1'b1, tail[26:0]};
    endfunction

    // Exact product, one rounding to nearest even, clamped to minpos..maxpos
    function automatic logic [31:0] ref_mul(input logic [31:0] a, input logic [31:0] b);
        logic         sa;
        logic         sb;
        int           ea;
        int           eb;
        logic [27:0]  ma;
        logic [27:0]  mb;
        logic [55:0]  prod;
        logic [127:0] str;
        logic [30:0]  body;
        int           sc;
        int           k;
        int           pos;
        if (a == NAR || b == NAR) return NAR;
        if (a == '0 || b == '0) return '0;
        decode(a, sa, ea, ma);
        decode(b, sb, eb, mb);
        prod = ma * mb;
        sc   = ea + eb;
        if (prod[55]) sc++;
        else prod = prod << 1;                   // Hidden one at bit 55
        if (sc > 120) begin
            body = '1;                           // maxpos
        end else if (sc < -120) begin
            body = 31'd1;                        // minpos
        end else begin
            k   = sc >>> 2;
            str = '0;
            pos = 127;
            if (k >= 0) begin
                for (int i = 0; i <= k; i++) begin
                    str[pos] = 1'b1;
                    pos--;
                end
                pos--;                           // Terminating zero
            end else begin
                pos = pos + k;                   // Zero run
                str[pos] = 1'b1;
                pos--;
            end
            str[pos]     = sc[1];
            str[pos - 1] = sc[0];
            pos = pos - 2;
            for (int i = 54; i >= 0; i--) begin
                str[pos] = prod[i];
                pos--;
            end
            body = str[127:97];
            if (str[96] && (body[0] || (|str[95:0]))) body++;
        end
        return (sa ^ sb) ? -{1'b0, body} : {1'b0, body};
    endfunction

    function automatic logic [31:0] ref_status(input logic [31:0] a, input logic [31:0] b);
        if (a == NAR || b == NAR) return 32'h3;  // done, inf
        if (a == '0 || b == '0) return 32'h5;    // done, zero
        return 32'h1;
    endfunction

    task automatic mul_check(input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp);
        logic [31:0] data;
        int          lat;
        apb_write(`REG_OPA, a);
        apb_write(`REG_OPB, b);
        wait_done(lat);
        check_eq(lat, 3, "done latency");
        apb_read(`REG_RESULT, data);
        check_eq(data, exp, $sformatf("%h x %h", a, b));
        apb_read(`REG_STATUS, data);
        check_eq(data, ref_status(a, b), "status");
    endtask

    task automatic finish_test(input string name, input int err_start);
        $display("%-16s finished with %0d errors", name, errors - err_start);
    endtask

    task automatic test_reset_readback();
        logic [31:0] data;
        int          e0 = errors;
        apb_read(`REG_STATUS, data);
        check_eq(data, 32'h0, "status after reset");
        apb_read(`REG_RESULT, data);
        check_eq(data, 32'h0, "result after reset");
        apb_write(`REG_OPA, 32'h1234_5678);
        apb_write(`REG_OPB, 32'h9abc_def0);
        apb_read(`REG_OPA, data);
        check_eq(data, 32'h1234_5678, "OPA readback");
        apb_read(`REG_OPB, data);
        check_eq(data, 32'h9abc_def0, "OPB readback");
        apb_read(4'h2, data);                    // Unmapped offset
        check_eq(data, 32'h0, "unmapped read");
        finish_test("reset_readback", e0);
    endtask

    task automatic test_exact();
        int e0 = errors;
        mul_check(32'h4000_0000, 32'h4000_0000, 32'h4000_0000);   // 1 x 1
        mul_check(32'h4800_0000, 32'h3800_0000, 32'h4000_0000);   // 2 x 0.5
        mul_check(32'hC000_0000, 32'h5000_0000, 32'hB000_0000);   // -1 x 4
        finish_test("exact", e0);
    endtask

    task automatic test_special();
        int e0 = errors;
        mul_check(32'h0000_0000, 32'h4800_0000, 32'h0000_0000);
        mul_check(32'h5AB0_0000, 32'h0000_0000, 32'h0000_0000);
        mul_check(NAR, 32'h4000_0000, NAR);
        mul_check(32'h0000_0000, NAR, NAR);      // NaR wins over zero
        finish_test("special", e0);
    endtask

    task automatic test_rounding();
        logic [31:0] pairs [12];
        int          e0 = errors;
        pairs = '{32'h4000_2000, 32'h4000_2000,  // Tie, even stays
                  32'h4400_0000, 32'h4000_0001,  // Tie, odd goes up
                  32'h4000_2000, 32'h4000_2001,  // Just above half
                  32'h6000_2000, 32'h6000_2000,  // Tie, longer regime
                  32'h6000_2000, 32'h6000_0001,  // Above half, longer regime
                  32'hBFFF_E000, 32'h4000_2000}; // Negative tie
        for (int i = 0; i < 12; i += 2) begin
            mul_check(pairs[i], pairs[i + 1], ref_mul(pairs[i], pairs[i + 1]));
        end
        finish_test("rounding", e0);
    endtask

    task automatic test_range();
        int e0 = errors;
        mul_check(32'h7FFF_FFFF, 32'h7FFF_FFFF, 32'h7FFF_FFFF);
        mul_check(32'h0000_0001, 32'h0000_0001, 32'h0000_0001);
        mul_check(32'h8000_0001, 32'h7FFF_FFFF, 32'h8000_0001);   // -maxpos
        mul_check(32'hFFFF_FFFF, 32'h0000_0001, 32'hFFFF_FFFF);   // -minpos
        finish_test("range", e0);
    endtask

    task automatic test_random();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] data;
        logic [31:0] burst [3];
        int          e0 = errors;
        for (int i = 0; i < 200; i++) begin
            a = lcg_next();
            b = lcg_next();
            mul_check(a, b, ref_mul(a, b));
        end
        // Overlapping products in the pipeline, last one must stay in RESULT
        a = lcg_next();
        foreach (burst[i]) begin
            burst[i] = lcg_next();
        end
        apb_write(`REG_OPA, a);
        apb_write_burst(`REG_OPB, burst);
        repeat (3) @(negedge clk);               // Pipeline drain
        apb_read(`REG_RESULT, data);
        check_eq(data, ref_mul(a, burst[2]), "back-to-back result");
        apb_read(`REG_STATUS, data);
        check_eq(data, ref_status(a, burst[2]), "back-to-back status");
        finish_test("random", e0);
    endtask

    initial begin
        rst     = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_readback();
        test_exact();
        test_special();
        test_rounding();
        test_range();
        test_random();
        $display("%0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+include
hw/posit_defines.sv
hw/posit_apb_slave.sv
hw/posit_extract.sv
hw/posit_mult.sv
hw/posit_normalize.sv
hw/posit_mul_apb.sv
testbench/posit_mul_apb_chk.sv
testbench/tb_posit_mul_apb.sv

// File: run.sh
#!/bin/sh
# Build the posit multiplier testbench with Verilator, run it, grep for the pass line
verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_posit_mul_apb -o sim_posit_mul_apb || exit 1
out="$(./obj_dir/sim_posit_mul_apb)"
status=$?
echo "$out"
[ $status -eq 0 ] && echo "$out" | grep -q "^Testbench passed$" && exit 0 || exit 1
